// File: common/core_pkg.sv
/*
 * core-wide widths and encodings for the rv32 trap unit
 * datapath and address widths, pipeline hold levels and the
 * payload types that the register stages are built with
 */
`default_nettype none

package core_pkg;

    // datapath widths
    localparam int XLEN        = 32;
    localparam int INST_ADDR_W = 32;  // pc width
    localparam int CSR_ADDR_W  = 12;  // full csr address space

    // payload types for gnrl_dff stages
    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [INST_ADDR_W-1:0] inst_addr_t;
    typedef logic [CSR_ADDR_W-1:0]  csr_addr_t;

    // hold levels seen by ctrl
    localparam logic HOLD_ENABLE  = 1'b1;
    localparam logic HOLD_DISABLE = 1'b0;

    // bytes per instruction, no compressed ext
    localparam inst_addr_t INST_STEP = inst_addr_t'(4);

endpackage : core_pkg

`default_nettype wire

// File: common/csr_pkg.sv
/*
 * machine-mode csr definitions
 * trap csr addresses, exception cause codes and the
 * mstatus interrupt-enable bit positions
 */
`default_nettype none

package csr_pkg;

    // machine trap setup / handling addresses
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    // sync exception causes, interrupt bit clear
    localparam logic [31:0] CAUSE_ECALL_M    = 32'd11;  // ecall from m-mode
    localparam logic [31:0] CAUSE_BREAKPOINT = 32'd3;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;  // global m-mode int enable
    localparam int MSTATUS_MPIE_BIT = 7;  // mie before the trap

endpackage : csr_pkg

`default_nettype wire

// File: hdl/gnrl_dff.sv
/*
 * general register stage
 * loads its input on every clock edge and clears to zero on
 * an asynchronous active-low reset, payload type set per instance
 */
`timescale 1ns/1ps
`default_nettype none

module gnrl_dff #(
    parameter type T = logic  // payload, single bit unless overridden
) (
    input  wire   clk,
    input  wire   rst_n_i,
    input  wire T dnxt_i,
    output T      qout_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            qout_o <= '0;  // zero for every payload
        end else begin
            qout_o <= dnxt_i;
        end
    end

endmodule : gnrl_dff

`default_nettype wire

// File: clint/csr_reg.sv
/*
 * machine trap csr file
 * mstatus, mtvec, mepc, mcause and mscratch behind a wishbone
 * classic slave, with a sequencer write port that takes priority
 * and back-pressures the bus
 */
`timescale 1ns/1ps
`default_nettype none

module csr_reg
    import core_pkg::*;
    import csr_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,

    // sequencer write port from clint
    input  wire            csr_we_i,
    input  wire csr_addr_t csr_waddr_i,
    input  wire xlen_t     csr_wdata_i,

    // wishbone classic slave
    input  wire            wb_cyc_i,
    input  wire            wb_stb_i,
    input  wire            wb_we_i,
    input  wire csr_addr_t wb_adr_i,
    input  wire xlen_t     wb_dat_i,
    output xlen_t          wb_dat_o,
    output logic           wb_ack_o,

    // live values back to clint
    output xlen_t          csr_mtvec_o,
    output xlen_t          csr_mepc_o,
    output xlen_t          csr_mstatus_o
);

    xlen_t     mstatus;
    xlen_t     mtvec;      // bits 1:0 held at zero
    xlen_t     mepc;
    xlen_t     mcause;
    xlen_t     mscratch;

    logic      bus_go;     // bus cycle completes at this edge
    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;
    xlen_t     rd_data;

    // sequencer write blocks the bus, ~ack stops a second ack
    assign bus_go = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~csr_we_i;

    // one shared write port, sequencer first
    assign wr_en   = csr_we_i | (bus_go & wb_we_i);
    assign wr_addr = csr_we_i ? csr_waddr_i : wb_adr_i;
    assign wr_data = csr_we_i ? csr_wdata_i : wb_dat_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                CSR_MSTATUS:  mstatus  <= wr_data;
                CSR_MTVEC:    mtvec    <= {wr_data[XLEN-1:2], 2'b00};  // direct mode
                CSR_MEPC:     mepc     <= wr_data;
                CSR_MCAUSE:   mcause   <= wr_data;
                CSR_MSCRATCH: mscratch <= wr_data;
                default: ;  // unmapped, write dropped
            endcase
        end
    end

    // bus read mux
    always_comb begin
        case (wb_adr_i)
            CSR_MSTATUS:  rd_data = mstatus;
            CSR_MTVEC:    rd_data = mtvec;
            CSR_MEPC:     rd_data = mepc;
            CSR_MCAUSE:   rd_data = mcause;
            CSR_MSCRATCH: rd_data = mscratch;
            default:      rd_data = '0;  // unmapped reads zero
        endcase
    end

    // single-cycle registered ack
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= bus_go;
        end
    end

    // read data rides along with the ack
    always_ff @(posedge clk) begin
        if (bus_go && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

    assign csr_mtvec_o   = mtvec;
    assign csr_mepc_o    = mepc;
    assign csr_mstatus_o = mstatus;

endmodule : csr_reg

`default_nettype wire

// File: clint/clint.sv
/*
 * core-local trap sequencer
 * takes ecall / ebreak / mret from ex, stalls the pipe while it
 * writes mepc, mstatus and mcause in turn, then redirects fetch
 * to mtvec (trap) or mepc (return)
 */
`timescale 1ns/1ps
`default_nettype none

module clint
    import core_pkg::*;
    import csr_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n_i,

    // from id
    input  wire inst_addr_t inst_addr_i,

    // from ex
    input  wire             jump_flag_i,
    input  wire inst_addr_t jump_addr_i,
    input  wire             muldiv_started_i,  // divider busy, traps wait
    input  wire             sys_op_ecall_i,
    input  wire             sys_op_ebreak_i,
    input  wire             sys_op_mret_i,

    // live values from csr_reg
    input  wire xlen_t      csr_mtvec_i,
    input  wire xlen_t      csr_mepc_i,
    input  wire xlen_t      csr_mstatus_i,

    // to ctrl
    output logic            hold_flag_o,

    // to csr_reg
    output logic            csr_we_o,
    output csr_addr_t       csr_waddr_o,
    output xlen_t           csr_wdata_o,

    // to ex, fetch redirect
    output inst_addr_t      int_addr_o,
    output logic            int_assert_o
);

    // csr write fsm, one-hot with idle as the all-zero code
    typedef logic [3:0] csr_state_t;

    localparam csr_state_t S_CSR_IDLE         = 4'b0000;  // matches dff reset value
    localparam csr_state_t S_CSR_MEPC         = 4'b0001;
    localparam csr_state_t S_CSR_MSTATUS      = 4'b0010;
    localparam csr_state_t S_CSR_MCAUSE       = 4'b0100;
    localparam csr_state_t S_CSR_MSTATUS_MRET = 4'b1000;

    csr_state_t csr_state;
    csr_state_t next_csr_state;
    xlen_t      cause;            // latched at request
    xlen_t      next_cause;
    inst_addr_t saved_addr;       // return pc for mepc
    inst_addr_t next_saved_addr;

    logic       csr_idle;
    logic       sync_req;         // ecall / ebreak taken this cycle
    logic       mret_req;         // mret taken this cycle

    xlen_t      trap_mstatus;
    xlen_t      mret_mstatus;

    logic       next_we;
    csr_addr_t  next_waddr;
    xlen_t      next_wdata;
    logic       next_int_assert;
    inst_addr_t next_int_addr;

    // request decode, only while the write fsm is idle
    assign csr_idle = (csr_state == S_CSR_IDLE);
    assign sync_req = csr_idle & (sys_op_ecall_i | sys_op_ebreak_i) & ~muldiv_started_i;
    assign mret_req = csr_idle & sys_op_mret_i & ~sync_req;  // trap wins if both

    // stall in the request cycle and for the whole sequence
    assign hold_flag_o = (sync_req | mret_req | ~csr_idle) ? HOLD_ENABLE : HOLD_DISABLE;

    always_comb begin
        case (csr_state)
            S_CSR_IDLE: begin
                if (sync_req) begin
                    next_csr_state = S_CSR_MEPC;
                end else if (mret_req) begin
                    next_csr_state = S_CSR_MSTATUS_MRET;
                end else begin
                    next_csr_state = S_CSR_IDLE;
                end
            end
            S_CSR_MEPC:    next_csr_state = S_CSR_MSTATUS;
            S_CSR_MSTATUS: next_csr_state = S_CSR_MCAUSE;
            default:       next_csr_state = S_CSR_IDLE;  // mcause / mret are last
        endcase
    end

    // ecall has priority over ebreak
    assign next_cause = !sync_req      ? cause         :
                        sys_op_ecall_i ? CAUSE_ECALL_M : CAUSE_BREAKPOINT;

    // pending jump means ex already moved on, step back to the trapping inst
    assign next_saved_addr = !sync_req   ? saved_addr              :
                             jump_flag_i ? jump_addr_i - INST_STEP : inst_addr_i;

    // mstatus update, built from the live register value
    always_comb begin
        trap_mstatus                   = csr_mstatus_i;
        trap_mstatus[MSTATUS_MPIE_BIT] = csr_mstatus_i[MSTATUS_MIE_BIT];  // keep old mie
        trap_mstatus[MSTATUS_MIE_BIT]  = 1'b0;                            // ints off in handler

        mret_mstatus                   = csr_mstatus_i;
        mret_mstatus[MSTATUS_MIE_BIT]  = csr_mstatus_i[MSTATUS_MPIE_BIT];
        mret_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
    end

    // csr write port and redirect, registered below
    always_comb begin
        next_we         = ~csr_idle;
        next_waddr      = '0;
        next_wdata      = '0;
        next_int_assert = 1'b0;
        next_int_addr   = '0;
        case (csr_state)
            S_CSR_MEPC: begin
                next_waddr = CSR_MEPC;
                next_wdata = saved_addr;
            end
            S_CSR_MSTATUS: begin
                next_waddr = CSR_MSTATUS;
                next_wdata = trap_mstatus;
            end
            S_CSR_MCAUSE: begin
                next_waddr      = CSR_MCAUSE;
                next_wdata      = cause;
                next_int_assert = 1'b1;
                next_int_addr   = csr_mtvec_i;  // direct mode only
            end
            S_CSR_MSTATUS_MRET: begin
                next_waddr      = CSR_MSTATUS;
                next_wdata      = mret_mstatus;
                next_int_assert = 1'b1;
                next_int_addr   = csr_mepc_i;   // back to the saved pc
            end
            default: ;
        endcase
    end

    gnrl_dff #(.T(csr_state_t)) csr_state_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_csr_state),
        .qout_o (csr_state)
    );

    gnrl_dff #(.T(xlen_t)) cause_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_cause),
        .qout_o (cause)
    );

    gnrl_dff #(.T(inst_addr_t)) saved_addr_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_saved_addr),
        .qout_o (saved_addr)
    );

    gnrl_dff #(.T(logic)) csr_we_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_we),
        .qout_o (csr_we_o)
    );

    gnrl_dff #(.T(csr_addr_t)) csr_waddr_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_waddr),
        .qout_o (csr_waddr_o)
    );

    gnrl_dff #(.T(xlen_t)) csr_wdata_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_wdata),
        .qout_o (csr_wdata_o)
    );

    gnrl_dff #(.T(logic)) int_assert_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_int_assert),
        .qout_o (int_assert_o)
    );

    gnrl_dff #(.T(inst_addr_t)) int_addr_dff (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .dnxt_i (next_int_addr),
        .qout_o (int_addr_o)
    );

endmodule : clint

`default_nettype wire

// File: hdl/trap_unit_top.sv
/*
 * machine-mode trap unit
 * trap sequencer plus its csr file, with the pipeline side
 * and the wishbone csr port brought out
 */
`timescale 1ns/1ps
`default_nettype none

module trap_unit_top
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n_i,

    // pipeline side
    input  wire inst_addr_t inst_addr_i,
    input  wire             jump_flag_i,
    input  wire inst_addr_t jump_addr_i,
    input  wire             muldiv_started_i,
    input  wire             sys_op_ecall_i,
    input  wire             sys_op_ebreak_i,
    input  wire             sys_op_mret_i,
    output logic            hold_flag_o,
    output inst_addr_t      int_addr_o,
    output logic            int_assert_o,

    // csr bus, stands in for csr instructions
    input  wire             wb_cyc_i,
    input  wire             wb_stb_i,
    input  wire             wb_we_i,
    input  wire csr_addr_t  wb_adr_i,
    input  wire xlen_t      wb_dat_i,
    output xlen_t           wb_dat_o,
    output logic            wb_ack_o
);

    logic      csr_we;       // sequencer write strobe
    csr_addr_t csr_waddr;
    xlen_t     csr_wdata;
    xlen_t     csr_mtvec;    // live csr values into clint
    xlen_t     csr_mepc;
    xlen_t     csr_mstatus;

    clint u_clint (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_addr_i     (inst_addr_i),
        .jump_flag_i     (jump_flag_i),
        .jump_addr_i     (jump_addr_i),
        .muldiv_started_i(muldiv_started_i),
        .sys_op_ecall_i  (sys_op_ecall_i),
        .sys_op_ebreak_i (sys_op_ebreak_i),
        .sys_op_mret_i   (sys_op_mret_i),
        .csr_mtvec_i     (csr_mtvec),
        .csr_mepc_i      (csr_mepc),
        .csr_mstatus_i   (csr_mstatus),
        .hold_flag_o     (hold_flag_o),
        .csr_we_o        (csr_we),
        .csr_waddr_o     (csr_waddr),
        .csr_wdata_o     (csr_wdata),
        .int_addr_o      (int_addr_o),
        .int_assert_o    (int_assert_o)
    );

    csr_reg u_csr_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .csr_we_i     (csr_we),
        .csr_waddr_i  (csr_waddr),
        .csr_wdata_i  (csr_wdata),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .csr_mtvec_o  (csr_mtvec),
        .csr_mepc_o   (csr_mepc),
        .csr_mstatus_o(csr_mstatus)
    );

endmodule : trap_unit_top

`default_nettype wire

// File: sim/trap_unit_properties.sv
/*
 * trap unit protocol properties
 * bound into trap_unit_top to check redirect timing against
 * the live csr values and the wishbone ack rules
 */
`timescale 1ns/1ps
`default_nettype none

module trap_unit_properties
    import core_pkg::*;
(
    input wire             clk,
    input wire             rst_n_i,
    input wire             muldiv_started_i,
    input wire             sys_op_ecall_i,
    input wire             sys_op_ebreak_i,
    input wire             sys_op_mret_i,
    input wire             hold_flag_o,
    input wire             int_assert_o,
    input wire inst_addr_t int_addr_o,
    input wire xlen_t      csr_mtvec_i,
    input wire xlen_t      csr_mepc_i,
    input wire             wb_cyc_i,
    input wire             wb_stb_i,
    input wire             wb_ack_o
);

    logic        sync_acc;        // ecall / ebreak taken at this edge
    logic        mret_acc;
    int unsigned fail_count = 0;  // failed property checks so far

    // flags only come up while the sequencer is idle
    assign sync_acc = (sys_op_ecall_i | sys_op_ebreak_i) & ~muldiv_started_i;
    assign mret_acc = sys_op_mret_i & ~sync_acc;

    // redirect is a single-cycle pulse
    a_int_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        int_assert_o |-> !$past(int_assert_o))
        else begin
            fail_count++;
            $error("int_assert_o held longer than one cycle");
        end

    // mepc, mstatus and mcause written before the jump to mtvec
    a_trap_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        sync_acc |-> ##4 (int_assert_o && int_addr_o == csr_mtvec_i))
        else begin
            fail_count++;
            $error("trap redirect missing or wrong target");
        end

    a_mret_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        mret_acc |-> ##2 (int_assert_o && int_addr_o == csr_mepc_i))
        else begin
            fail_count++;
            $error("mret redirect missing or wrong target");
        end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else begin
            fail_count++;
            $error("ack outside a bus cycle");
        end

    // requester must wait for the stall to clear
    a_no_req_in_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        ($rose(sys_op_ecall_i) || $rose(sys_op_ebreak_i) || $rose(sys_op_mret_i))
            |-> !$past(hold_flag_o))
        else begin
            fail_count++;
            $error("system op raised during hold");
        end

endmodule : trap_unit_properties

bind trap_unit_top trap_unit_properties props_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .muldiv_started_i(muldiv_started_i),
    .sys_op_ecall_i  (sys_op_ecall_i),
    .sys_op_ebreak_i (sys_op_ebreak_i),
    .sys_op_mret_i   (sys_op_mret_i),
    .hold_flag_o     (hold_flag_o),
    .int_assert_o    (int_assert_o),
    .int_addr_o      (int_addr_o),
    .csr_mtvec_i     (csr_mtvec),
    .csr_mepc_i      (csr_mepc),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_ack_o        (wb_ack_o)
);

`default_nettype wire

// File: sim/trap_unit_tb.sv
/*
 * trap unit testbench
 * plays id, ex and ctrl on the pipeline side and a wishbone
 * master on the csr bus and checks csr values after each trap
 */
`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb
    import core_pkg::*;
    import csr_pkg::*;
;

    logic       clk;
    logic       rst_n_i;
    inst_addr_t inst_addr_i;
    logic       jump_flag_i;
    inst_addr_t jump_addr_i;
    logic       muldiv_started_i;
    logic       sys_op_ecall_i;
    logic       sys_op_ebreak_i;
    logic       sys_op_mret_i;
    logic       hold_flag_o;
    inst_addr_t int_addr_o;
    logic       int_assert_o;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    csr_addr_t  wb_adr_i;
    xlen_t      wb_dat_i;
    xlen_t      wb_dat_o;
    logic       wb_ack_o;

    xlen_t      v;
    xlen_t      ms;
    xlen_t      ms_exp;
    xlen_t      mtvec_exp;
    inst_addr_t pc;
    int         waits;

    trap_unit_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string what, input xlen_t got, input xlen_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            fail_run("value mismatch");
        end
    endtask

    // one classic cycle with stb held through the ack cycle
    task automatic wb_cycle(input logic we, input csr_addr_t adr, input xlen_t dat,
                            output xlen_t rdat, output int n);
        n = 0;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        do begin
            @(negedge clk);
            n++;
            if (n > 20) fail_run("bus cycle never acknowledged");
        end while (!wb_ack_o);
        rdat = wb_dat_o;
        @(negedge clk);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input csr_addr_t adr, input xlen_t dat, output int n);
        xlen_t unused;
        wb_cycle(1'b1, adr, dat, unused, n);
    endtask

    task automatic wb_read(input csr_addr_t adr, output xlen_t dat);
        int n;
        wb_cycle(1'b0, adr, '0, dat, n);
    endtask

    task automatic read_check(input string what, input csr_addr_t adr, input xlen_t exp);
        xlen_t got;
        wb_read(adr, got);
        check_eq(what, got, exp);
    endtask

    // waits until the sequencer takes the raised flags
    task automatic wait_accept();
        int n;
        n = 0;
        #1;
        while (!hold_flag_o) begin
            @(negedge clk);
            #1;
            n++;
            if (n > 20) fail_run("system op never accepted");
        end
        @(negedge clk);
        sys_op_ecall_i  = 1'b0;
        sys_op_ebreak_i = 1'b0;
        sys_op_mret_i   = 1'b0;
    endtask

    // stall must stay up until the redirect pulse
    task automatic wait_redirect(input xlen_t exp_addr);
        int n;
        n = 0;
        while (!int_assert_o) begin
            check_eq("hold_flag_o during trap", hold_flag_o, 1);
            @(negedge clk);
            n++;
            if (n > 20) fail_run("redirect never asserted");
        end
        check_eq("int_addr_o", int_addr_o, exp_addr);
    endtask

    initial begin
        #(6 * 40 * 4);
        fail_run("watchdog expired, simulation hung");
    end

    // a bound property failure stops the run
    initial begin
        wait (dut_i.props_i.fail_count != 0);
        fail_run("protocol property check failed");
    end

    initial begin
        void'($urandom(32'hcbdf_0505));
        rst_n_i          = 1'b0;
        inst_addr_i      = '0;
        jump_flag_i      = 1'b0;
        jump_addr_i      = '0;
        muldiv_started_i = 1'b0;
        sys_op_ecall_i   = 1'b0;
        sys_op_ebreak_i  = 1'b0;
        sys_op_mret_i    = 1'b0;
        wb_cyc_i         = 1'b0;
        wb_stb_i         = 1'b0;
        wb_we_i          = 1'b0;
        wb_adr_i         = '0;
        wb_dat_i         = '0;
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;

        // reset state
        check_eq("hold_flag_o after reset", hold_flag_o, 0);
        check_eq("int_assert_o after reset", int_assert_o, 0);
        read_check("mstatus reset", CSR_MSTATUS, 0);
        read_check("mtvec reset", CSR_MTVEC, 0);
        read_check("mepc reset", CSR_MEPC, 0);
        read_check("mcause reset", CSR_MCAUSE, 0);
        read_check("mscratch reset", CSR_MSCRATCH, 0);

        // bus readback with mtvec in direct mode only
        v = $urandom;
        wb_write(CSR_MTVEC, v, waits);
        read_check("mtvec readback", CSR_MTVEC, {v[31:2], 2'b00});
        v = $urandom;
        wb_write(CSR_MEPC, v, waits);
        read_check("mepc readback", CSR_MEPC, v);
        v = $urandom;
        wb_write(CSR_MSTATUS, v, waits);
        read_check("mstatus readback", CSR_MSTATUS, v);
        v = $urandom;
        wb_write(CSR_MSCRATCH, v, waits);
        read_check("mscratch readback", CSR_MSCRATCH, v);
        do v = $urandom & 32'hfff;
        while (v inside {CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MSCRATCH});
        read_check("unmapped csr", csr_addr_t'(v), 0);

        // ecall with no pending jump and mie set
        mtvec_exp = $urandom & 32'hffff_fffc;
        wb_write(CSR_MTVEC, mtvec_exp, waits);
        ms = $urandom | (32'd1 << MSTATUS_MIE_BIT);
        wb_write(CSR_MSTATUS, ms, waits);
        pc = $urandom & 32'hffff_fffc;
        @(negedge clk);
        inst_addr_i    = pc;
        sys_op_ecall_i = 1'b1;
        wait_accept();
        wait_redirect(mtvec_exp);
        ms_exp = ms;
        ms_exp[MSTATUS_MPIE_BIT] = 1'b1;
        ms_exp[MSTATUS_MIE_BIT]  = 1'b0;
        read_check("mepc after ecall", CSR_MEPC, pc);
        read_check("mcause after ecall", CSR_MCAUSE, 11);
        read_check("mstatus after ecall", CSR_MSTATUS, ms_exp);

        // ebreak behind a busy divider with a jump pending
        pc = $urandom & 32'hffff_fffc;
        @(negedge clk);
        muldiv_started_i = 1'b1;
        jump_flag_i      = 1'b1;
        jump_addr_i      = pc;
        sys_op_ebreak_i  = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_eq("hold_flag_o while divider busy", hold_flag_o, 0);
            check_eq("int_assert_o while divider busy", int_assert_o, 0);
        end
        muldiv_started_i = 1'b0;
        wait_accept();
        jump_flag_i = 1'b0;
        wait_redirect(mtvec_exp);
        read_check("mepc after ebreak", CSR_MEPC, pc - 4);
        read_check("mcause after ebreak", CSR_MCAUSE, 3);
        ms_exp[MSTATUS_MPIE_BIT] = 1'b0;  // mie was already clear
        read_check("mstatus after ebreak", CSR_MSTATUS, ms_exp);

        // mret with mpie set and mie clear
        ms = ($urandom & ~(32'd1 << MSTATUS_MIE_BIT)) | (32'd1 << MSTATUS_MPIE_BIT);
        wb_write(CSR_MSTATUS, ms, waits);
        @(negedge clk);
        sys_op_mret_i = 1'b1;
        wait_accept();
        wait_redirect(pc - 4);
        ms_exp = ms | (32'd1 << MSTATUS_MIE_BIT);
        read_check("mstatus after mret", CSR_MSTATUS, ms_exp);

        // bus write lands on top of the sequencer writes
        ms = ms_exp;
        pc = $urandom & 32'hffff_fffc;
        v  = $urandom;
        @(negedge clk);
        inst_addr_i    = pc;
        sys_op_ecall_i = 1'b1;
        wait_accept();
        wb_write(CSR_MSCRATCH, v, waits);
        // held off by the mepc, mstatus and mcause writes
        assert (waits == 4) else begin
            $display("CHECK FAILED at %0t ns: ack after %0d cycles, expected 4", $time, waits);
            fail_run("bus not back-pressured");
        end
        ms_exp = ms;
        ms_exp[MSTATUS_MPIE_BIT] = 1'b1;  // mie was set by the mret
        ms_exp[MSTATUS_MIE_BIT]  = 1'b0;
        read_check("mscratch after overlap", CSR_MSCRATCH, v);
        read_check("mepc after overlap", CSR_MEPC, pc);
        read_check("mcause after overlap", CSR_MCAUSE, 11);
        read_check("mstatus after overlap", CSR_MSTATUS, ms_exp);

        repeat (2) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule : trap_unit_tb

`default_nettype wire

// File: tb.f
common/core_pkg.sv
common/csr_pkg.sv
hdl/gnrl_dff.sv
clint/csr_reg.sv
clint/clint.sv
hdl/trap_unit_top.sv
sim/trap_unit_properties.sv
sim/trap_unit_tb.sv

// File: Makefile
# Verilator build and run of the trap unit testbench

VERILATOR ?= verilator
TOP       ?= trap_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
